/* include/matmul_defs.svh */
// Matmul tile engine width constants
// Element width for X, W and Y, accumulator width for Z
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// One X, W or Y element
localparam int unsigned DATA_W = 16;

// Accumulator and Z result, sums wrap at this width
localparam int unsigned ACC_W = 32;

`endif

/* logic/matmul_pkg.sv */
// Matmul tile engine package
// Element and accumulator types, plus the host load request format
package matmul_pkg;

  `include "matmul_defs.svh"

  // Signed operand element
  typedef logic signed [DATA_W-1:0] data_t;

  // Signed accumulator, also the Z result type
  typedef logic signed [ACC_W-1:0] acc_t;

  // Buffer targeted by a load
  typedef enum logic [1:0] {
    LOAD_X = 2'd0,
    LOAD_W = 2'd1,
    LOAD_Y = 2'd2
  } load_kind_e;

  // One element written by the host
  typedef struct packed {
    logic       valid;
    load_kind_e kind;
    data_t      data;
  } load_req_t;

endpackage : matmul_pkg

/* logic/step_counter.sv */
// Step counter
// Counts enabled cycles from zero, wraps after LIMIT-1 and flags the last step
`timescale 1ns/1ps

module step_counter #(
  parameter  int unsigned LIMIT = 4,
  localparam int unsigned CW    = (LIMIT > 1) ? $clog2(LIMIT) : 1
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          clear_i,
  input  logic          enable_i,
  output logic [CW-1:0] count_o,
  output logic          last_o
);

  logic [CW-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (enable_i) begin
      // Wrap so the next job starts from zero without an extra clear
      if (count_q == CW'(LIMIT - 1)) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign count_o = count_q;
  assign last_o  = (count_q == CW'(LIMIT - 1));

endmodule : step_counter

/* logic/matmul_scheduler.sv */
// Matmul job scheduler
// Sequences one job through compute, drain, store and output,
// and steers the buffers and the engine with single-cycle strobes
`timescale 1ns/1ps

module matmul_scheduler
  import matmul_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  input  logic step_last_i,
  input  logic out_last_i,
  output logic busy_o,
  output logic job_clear_o,
  output logic step_en_o,
  output logic acc_first_o,
  output logic drain_o,
  output logic store_o,
  output logic shift_out_o,
  output logic done_o
);

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    COMPUTE = 3'd1,
    DRAIN   = 3'd2,
    STORE   = 3'd3,
    OUTPUT  = 3'd4
  } state_e;

  state_e state_q, state_d;
  logic   first_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = COMPUTE;
      COMPUTE: if (step_last_i) state_d = DRAIN;
      // Last product still sits in the engine pipeline
      DRAIN:   state_d = STORE;
      STORE:   state_d = OUTPUT;
      OUTPUT:  if (out_last_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      first_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Armed at job start, consumed by the first compute step
      if (job_clear_o) begin
        first_q <= 1'b1;
      end else if (step_en_o) begin
        first_q <= 1'b0;
      end
    end
  end

  // Start is only accepted in idle, later pulses fall through
  assign job_clear_o = (state_q == IDLE) && start_i;
  assign busy_o      = (state_q != IDLE);
  assign step_en_o   = (state_q == COMPUTE);
  assign acc_first_o = step_en_o && first_q;
  assign drain_o     = (state_q == DRAIN);
  assign store_o     = (state_q == STORE);
  assign shift_out_o = (state_q == OUTPUT);
  assign done_o      = shift_out_o && out_last_i;

endmodule : matmul_scheduler

/* logic/x_buffer.sv */
// X matrix buffer
// Stores the WIDTH x HEIGHT tile row-major and presents column k per step
`timescale 1ns/1ps

module x_buffer
  import matmul_pkg::*;
#(
  parameter  int unsigned WIDTH  = 4,
  parameter  int unsigned HEIGHT = 4,
  localparam int unsigned RW     = (WIDTH > 1) ? $clog2(WIDTH) : 1,
  localparam int unsigned KW     = (HEIGHT > 1) ? $clog2(HEIGHT) : 1
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   job_clear_i,
  input  logic                   busy_i,
  input  load_req_t              load_i,
  input  logic      [KW-1:0]     k_i,
  output data_t     [WIDTH-1:0]  x_col_o
);

  data_t [WIDTH-1:0][HEIGHT-1:0] x_q;
  logic  [RW-1:0]                row_q;
  logic  [KW-1:0]                col_q;
  logic                          wr_en;

  assign wr_en = load_i.valid && (load_i.kind == LOAD_X);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      x_q   <= '0;
      row_q <= '0;
      col_q <= '0;
    end else if (job_clear_i) begin
      row_q <= '0;
      col_q <= '0;
    end else if (wr_en) begin
      x_q[row_q][col_q] <= load_i.data;
      // Column runs fastest, the row steps at the end of each row
      if (col_q == KW'(HEIGHT - 1)) begin
        col_q <= '0;
        row_q <= (row_q == RW'(WIDTH - 1)) ? '0 : row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  always_comb begin
    for (int r = 0; r < WIDTH; r++) begin
      x_col_o[r] = x_q[r][k_i];
    end
  end

  // Host must not write while a job reads the tile
  assert property (@(posedge clk_i) disable iff (rst_i) busy_i |-> !load_i.valid);

endmodule : x_buffer

/* logic/w_buffer.sv */
// W vector buffer
// Stores HEIGHT weights and selects the one for the current step
`timescale 1ns/1ps

module w_buffer
  import matmul_pkg::*;
#(
  parameter  int unsigned HEIGHT = 4,
  localparam int unsigned KW     = (HEIGHT > 1) ? $clog2(HEIGHT) : 1
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              job_clear_i,
  input  load_req_t         load_i,
  input  logic     [KW-1:0] k_i,
  output data_t             w_o
);

  data_t [HEIGHT-1:0] w_q;
  logic  [KW-1:0]     ptr_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_q   <= '0;
      ptr_q <= '0;
    end else if (job_clear_i) begin
      ptr_q <= '0;
    end else if (load_i.valid && (load_i.kind == LOAD_W)) begin
      w_q[ptr_q] <= load_i.data;
      ptr_q      <= (ptr_q == KW'(HEIGHT - 1)) ? '0 : ptr_q + 1'b1;
    end
  end

  // One weight is shared by every row in a step
  assign w_o = w_q[k_i];

endmodule : w_buffer

/* logic/mac_engine.sv */
// Multiply-accumulate engine
// Stage 1 registers one product per row, stage 2 adds it to the row
// accumulator, which the first step seeds with the bias
`timescale 1ns/1ps

module mac_engine
  import matmul_pkg::*;
#(
  parameter int unsigned WIDTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              step_en_i,
  input  logic              acc_first_i,
  input  data_t [WIDTH-1:0] x_col_i,
  input  data_t             w_i,
  input  data_t [WIDTH-1:0] bias_i,
  output acc_t  [WIDTH-1:0] acc_o
);

  acc_t [WIDTH-1:0] prod_q;
  logic             prod_valid_q;
  logic             prod_first_q;
  acc_t [WIDTH-1:0] acc_q;

  // Stage 1 products
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prod_valid_q <= 1'b0;
      prod_first_q <= 1'b0;
    end else begin
      prod_valid_q <= step_en_i;
      prod_first_q <= acc_first_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (step_en_i) begin
      for (int r = 0; r < WIDTH; r++) begin
        prod_q[r] <= acc_t'(x_col_i[r]) * acc_t'(w_i);
      end
    end
  end

  // Stage 2 accumulate, wraps at ACC_W
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_q <= '0;
    end else if (prod_valid_q) begin
      for (int r = 0; r < WIDTH; r++) begin
        if (prod_first_q) begin
          acc_q[r] <= acc_t'(bias_i[r]) + prod_q[r];
        end else begin
          acc_q[r] <= acc_q[r] + prod_q[r];
        end
      end
    end
  end

  assign acc_o = acc_q;

endmodule : mac_engine

/* logic/z_buffer.sv */
// Y/Z buffer
// Holds the bias vector for the engine, captures the finished sums
// and shifts them out one per cycle, row 0 first
`timescale 1ns/1ps

module z_buffer
  import matmul_pkg::*;
#(
  parameter  int unsigned WIDTH = 4,
  localparam int unsigned YW    = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              job_clear_i,
  input  load_req_t         load_i,
  input  logic              store_i,
  input  logic              shift_i,
  input  acc_t  [WIDTH-1:0] acc_i,
  output data_t [WIDTH-1:0] bias_o,
  output logic              z_valid_o,
  output acc_t              z_data_o
);

  data_t [WIDTH-1:0] y_q;
  logic  [YW-1:0]    y_ptr_q;
  acc_t  [WIDTH-1:0] z_q;

  // Bias side
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      y_q     <= '0;
      y_ptr_q <= '0;
    end else if (job_clear_i) begin
      y_ptr_q <= '0;
    end else if (load_i.valid && (load_i.kind == LOAD_Y)) begin
      y_q[y_ptr_q] <= load_i.data;
      y_ptr_q      <= (y_ptr_q == YW'(WIDTH - 1)) ? '0 : y_ptr_q + 1'b1;
    end
  end

  // Result side, slot 0 is always the next one out
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      z_q <= '0;
    end else if (store_i) begin
      z_q <= acc_i;
    end else if (shift_i) begin
      for (int r = 0; r < WIDTH - 1; r++) begin
        z_q[r] <= z_q[r+1];
      end
      z_q[WIDTH-1] <= '0;
    end
  end

  assign bias_o    = y_q;
  assign z_valid_o = shift_i;
  assign z_data_o  = z_q[0];

  // Capture and drain of the result store never overlap
  assert property (@(posedge clk_i) disable iff (rst_i) !(shift_i && store_i));

endmodule : z_buffer

/* logic/matmul_top.sv */
// Matmul tile engine top level
// Computes Z = X*W + Y for one tile per job
`timescale 1ns/1ps

module matmul_top
  import matmul_pkg::*;
#(
  parameter  int unsigned WIDTH  = 4,
  parameter  int unsigned HEIGHT = 4,
  localparam int unsigned KW     = (HEIGHT > 1) ? $clog2(HEIGHT) : 1
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  load_req_t load_i,
  input  logic      start_i,
  output logic      busy_o,
  output logic      z_valid_o,
  output acc_t      z_data_o,
  output logic      done_o
);

  logic              job_clear, step_en, acc_first, store, shift_out;
  logic              step_last, out_last;
  logic [KW-1:0]     k;
  data_t [WIDTH-1:0] x_col;
  data_t             w_elem;
  data_t [WIDTH-1:0] bias;
  acc_t  [WIDTH-1:0] acc;

  matmul_scheduler i_scheduler (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .start_i     ( start_i   ),
    .step_last_i ( step_last ),
    .out_last_i  ( out_last  ),
    .busy_o      ( busy_o    ),
    .job_clear_o ( job_clear ),
    .step_en_o   ( step_en   ),
    .acc_first_o ( acc_first ),
    .drain_o     (           ),
    .store_o     ( store     ),
    .shift_out_o ( shift_out ),
    .done_o      ( done_o    )
  );

  step_counter #( .LIMIT ( HEIGHT ) ) i_step_cnt (
    .clk_i    ( clk_i     ),
    .rst_i    ( rst_i     ),
    .clear_i  ( job_clear ),
    .enable_i ( step_en   ),
    .count_o  ( k         ),
    .last_o   ( step_last )
  );

  // Output slot counter, only its last flag matters
  step_counter #( .LIMIT ( WIDTH ) ) i_out_cnt (
    .clk_i    ( clk_i     ),
    .rst_i    ( rst_i     ),
    .clear_i  ( job_clear ),
    .enable_i ( shift_out ),
    .count_o  (           ),
    .last_o   ( out_last  )
  );

  x_buffer #( .WIDTH ( WIDTH ), .HEIGHT ( HEIGHT ) ) i_x_buffer (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .job_clear_i ( job_clear ),
    .busy_i      ( busy_o    ),
    .load_i      ( load_i    ),
    .k_i         ( k         ),
    .x_col_o     ( x_col     )
  );

  w_buffer #( .HEIGHT ( HEIGHT ) ) i_w_buffer (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .job_clear_i ( job_clear ),
    .load_i      ( load_i    ),
    .k_i         ( k         ),
    .w_o         ( w_elem    )
  );

  mac_engine #( .WIDTH ( WIDTH ) ) i_engine (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .step_en_i   ( step_en   ),
    .acc_first_i ( acc_first ),
    .x_col_i     ( x_col     ),
    .w_i         ( w_elem    ),
    .bias_i      ( bias      ),
    .acc_o       ( acc       )
  );

  z_buffer #( .WIDTH ( WIDTH ) ) i_z_buffer (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .job_clear_i ( job_clear ),
    .load_i      ( load_i    ),
    .store_i     ( store     ),
    .shift_i     ( shift_out ),
    .acc_i       ( acc       ),
    .bias_o      ( bias      ),
    .z_valid_o   ( z_valid_o ),
    .z_data_o    ( z_data_o  )
  );

endmodule : matmul_top

/* test/matmul_tb.sv */
// Matmul tile engine testbench
// Runs the jobs of the stimulus file through the DUT and checks the
// control levels, the timing of the result burst and every result
`timescale 1ns/1ps

module matmul_tb
  import matmul_pkg::*;
();

  // Each data line of the stimulus file holds four values
  localparam int unsigned WIDTH       = 4;
  localparam int unsigned HEIGHT      = 4;
  localparam int          IDX_W       = 2;
  // Burst window counted from the start cycle
  localparam int          FIRST_CYCLE = HEIGHT + 3;
  localparam int          LAST_CYCLE  = HEIGHT + 2 + WIDTH;
  // Quiet cycles watched after each burst, long enough to see a stray second job
  localparam int          TAIL        = HEIGHT + 3 + WIDTH;

  typedef struct packed {
    logic [8*16-1:0]               name;
    logic [2:0]                    mask;
    logic                          early_start;
    data_t [WIDTH-1:0][HEIGHT-1:0] x;
    data_t [HEIGHT-1:0]            w;
    data_t [WIDTH-1:0]             y;
    acc_t  [WIDTH-1:0]             z;
  } job_t;

  logic      clk = 1'b0;
  logic      rst;
  load_req_t load_req;
  logic      start;
  logic      busy;
  logic      z_valid;
  acc_t      z_data;
  logic      done;

  job_t      jobs[$];
  int        cycle_count   = 0;
  int        timeout_limit = 0;

  matmul_top #(
    .WIDTH  ( WIDTH  ),
    .HEIGHT ( HEIGHT )
  ) dut_i (
    .clk_i     ( clk      ),
    .rst_i     ( rst      ),
    .load_i    ( load_req ),
    .start_i   ( start    ),
    .busy_o    ( busy     ),
    .z_valid_o ( z_valid  ),
    .z_data_o  ( z_data   ),
    .done_o    ( done     )
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %0b, actual %0b", name, exp, act));
    end
  endtask

  task automatic check_acc(input string name, input acc_t exp, input acc_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %0d (0x%08h), actual %0d (0x%08h)",
                          name, exp, exp, act, act));
    end
  endtask

  task automatic check_quiet(input string when);
    check_bit({when, " busy_o"}, 1'b0, busy);
    check_bit({when, " z_valid_o"}, 1'b0, z_valid);
    check_bit({when, " done_o"}, 1'b0, done);
  endtask

  // Next line that is neither blank nor a comment, empty at end of file
  task automatic next_line(input int fd, output string line);
    string raw;
    int    rc;
    line = "";
    while (line == "" && !$feof(fd)) begin
      raw = "";
      rc  = $fgets(raw, fd);
      if (rc > 0 && raw.len() > 1 && raw.getc(0) != "#") begin
        line = raw;
      end
    end
  endtask

  task automatic read_quad(input int fd, input string tag, output logic [3:0][31:0] vals);
    string          line;
    logic [8*8-1:0] found;
    logic [31:0]    v0, v1, v2, v3;
    int             rc;
    next_line(fd, line);
    rc = $sscanf(line, "%s %h %h %h %h", found, v0, v1, v2, v3);
    if (rc != 5 || line.substr(0, 0) != tag) begin
      abort_run({"Stimulus file is short or malformed where a ", tag, " line was expected"});
    end
    vals = {v3, v2, v1, v0};
  endtask

  task automatic read_stimulus();
    int               fd;
    int               rc;
    string            line;
    logic [8*8-1:0]   found;
    logic [8*16-1:0]  name_buf;
    logic [2:0]       mask_buf;
    logic             early_buf;
    logic [3:0][31:0] q;
    job_t             job;
    fd = $fopen("test/matmul_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the stimulus file test/matmul_stimulus.txt");
    end else begin
      next_line(fd, line);
      while (line != "") begin
        job      = '0;
        name_buf = '0;
        rc = $sscanf(line, "%s %s %h %h", found, name_buf, mask_buf, early_buf);
        if (rc != 4 || line.substr(0, 2) != "job") begin
          abort_run({"Malformed job header in stimulus file: ", line});
        end
        job.name        = name_buf;
        job.mask        = mask_buf;
        job.early_start = early_buf;
        for (int r = 0; r < WIDTH; r++) begin
          read_quad(fd, "x", q);
          for (int k = 0; k < HEIGHT; k++) begin
            job.x[IDX_W'(r)][IDX_W'(k)] = q[IDX_W'(k)][DATA_W-1:0];
          end
        end
        read_quad(fd, "w", q);
        for (int k = 0; k < HEIGHT; k++) begin
          job.w[IDX_W'(k)] = q[IDX_W'(k)][DATA_W-1:0];
        end
        read_quad(fd, "y", q);
        for (int r = 0; r < WIDTH; r++) begin
          job.y[IDX_W'(r)] = q[IDX_W'(r)][DATA_W-1:0];
        end
        read_quad(fd, "z", q);
        for (int r = 0; r < WIDTH; r++) begin
          job.z[IDX_W'(r)] = q[IDX_W'(r)];
        end
        jobs.push_back(job);
        next_line(fd, line);
      end
      $fclose(fd);
    end
  endtask

  task automatic load_element(input load_kind_e kind, input data_t value);
    @(negedge clk);
    load_req.valid = 1'b1;
    load_req.kind  = kind;
    load_req.data  = value;
  endtask

  task automatic run_job(input job_t job);
    logic [IDX_W-1:0] row;
    logic             exp_valid;
    string            tag;
    row = '0;
    tag = $sformatf("%0s", job.name);
    // X goes in row-major, matching the buffer's write pointer
    if (job.mask[0]) begin
      for (int r = 0; r < WIDTH; r++) begin
        for (int k = 0; k < HEIGHT; k++) begin
          load_element(LOAD_X, job.x[IDX_W'(r)][IDX_W'(k)]);
        end
      end
    end
    if (job.mask[1]) begin
      for (int k = 0; k < HEIGHT; k++) begin
        load_element(LOAD_W, job.w[IDX_W'(k)]);
      end
    end
    if (job.mask[2]) begin
      for (int r = 0; r < WIDTH; r++) begin
        load_element(LOAD_Y, job.y[IDX_W'(r)]);
      end
    end
    // Cycle 0, start sampled in idle
    @(negedge clk);
    load_req = '0;
    start    = 1'b1;
    for (int c = 1; c <= LAST_CYCLE + TAIL; c++) begin
      @(negedge clk);
      exp_valid = (c >= FIRST_CYCLE) && (c <= LAST_CYCLE);
      check_bit($sformatf("%0s busy_o cycle %0d", tag, c), c <= LAST_CYCLE, busy);
      check_bit($sformatf("%0s z_valid_o cycle %0d", tag, c), exp_valid, z_valid);
      check_bit($sformatf("%0s done_o cycle %0d", tag, c), c == LAST_CYCLE, done);
      if (exp_valid) begin
        check_acc($sformatf("%0s z_data_o row %0d", tag, row), job.z[row], z_data);
        row = row + 1'b1;
      end
      // Second start in the middle of compute, must be ignored
      start = job.early_start && (c == 2);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      abort_run($sformatf("Timeout after %0d cycles, the jobs did not complete", cycle_count));
    end
  end

  initial begin
    rst      = 1'b1;
    start    = 1'b0;
    load_req = '0;
    read_stimulus();
    if (jobs.size() == 0) begin
      abort_run("The stimulus file holds no jobs");
    end
    // Loads, the job itself and its quiet tail for every job, plus margin for reset
    timeout_limit = jobs.size() *
                    (WIDTH * HEIGHT + HEIGHT + WIDTH + HEIGHT + 3 + WIDTH + TAIL) + 100;
    for (int c = 0; c < 7; c++) begin
      @(negedge clk);
      check_quiet($sformatf("reset cycle %0d", c));
      // Five rising edges have seen reset by now
      if (c == 4) begin
        rst = 1'b0;
      end
    end
    foreach (jobs[j]) begin
      run_job(jobs[j]);
    end
    $display("Regression passed");
    $finish;
  end

endmodule : matmul_tb

/* test/matmul_stimulus.txt */
# job <name> <load mask hex: bit0 X, bit1 W, bit2 Y> <second start while busy 0/1>
# x: one line per row X[r][0..3], w: W[0..3], y: Y[0..3], z: expected Z[0..3], all hex
job basic 7 0
x 0001 0002 0003 0004
x 0005 0006 0007 0008
x 0009 000a 000b 000c
x 000d 000e 000f 0010
w 0001 0002 0003 0004
y 000a 0014 001e 0028
z 00000028 0000005a 0000008c 000000be
job negative 7 0
x ffff 0002 fffd 0004
x 0064 ff38 012c fe70
x 0000 0000 0000 0000
x 8000 0001 0001 0001
w 0003 fffb 0007 fff7
y ffff 03e8 fff9 0005
z ffffffb9 00001f40 fffffff9 fffe7ffe
job wrap 7 0
x 8000 8000 8000 8000
x 7fff 7fff 7fff 7fff
x 8000 8000 8000 0000
x 8000 8000 0000 0000
w 8000 8000 8000 8000
y 0001 0000 ffff 7fff
z 00000001 00020000 bfffffff 80007fff
job w_only 2 0
x 0000 0000 0000 0000
x 0000 0000 0000 0000
x 0000 0000 0000 0000
x 0000 0000 0000 0000
w 0001 0000 0000 0000
y 0000 0000 0000 0000
z ffff8001 00007fff ffff7fff ffffffff
job busy_start 7 1
x 0002 0000 0000 0000
x 0000 0003 0000 0000
x 0000 0000 fffc 0000
x 0001 0001 0001 0001
w 0064 00c8 012c 0190
y 0000 0001 0002 0003
z 000000c8 00000259 fffffb52 000003eb

/* sources.f */
+incdir+include
logic/matmul_pkg.sv
logic/step_counter.sv
logic/matmul_scheduler.sv
logic/x_buffer.sv
logic/w_buffer.sv
logic/mac_engine.sv
logic/z_buffer.sv
logic/matmul_top.sv
test/matmul_tb.sv

/* Makefile */
# Verilator flow for the matmul tile engine
# The simulation exits non-zero when the testbench stops with $fatal

TOP := matmul_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
